// File: include/enc_settings.svh
// Build-time constants for the encoder interface; include wherever sizes or addresses are needed
`ifndef ENC_SETTINGS_SVH
`define ENC_SETTINGS_SVH

// ---------------------------------------------------------------------------
// channel and filter sizing
// ---------------------------------------------------------------------------
`define ENC_NUM_CH        4           // channels numbered 1 to ENC_NUM_CH
`define ENC_FILT_LEN      3           // stable cycles before a line is accepted

// prescaler ratios
`define ENC_FAST_DIV      4           // sysclk cycles per fast tick
`define ENC_SLOW_DIV      256         // fast ticks per slow window

`define ENC_PRELOAD_INIT  24'h800000  // half scale

// ---------------------------------------------------------------------------
// register address map
// ---------------------------------------------------------------------------
`define ENC_BLK_MSB       15          // block field
`define ENC_BLK_LSB       12
`define ENC_CH_MSB        7           // channel field
`define ENC_CH_LSB        4
`define ENC_OFF_MSB       3           // offset field
`define ENC_OFF_LSB       0

`define ENC_ADDR_MAIN     4'h0

`define ENC_OFF_LOAD      4'h0        // preload readable and writable
`define ENC_OFF_DATA      4'h1        // count with overflow flag
`define ENC_OFF_PERD      4'h2        // period measurement
`define ENC_OFF_FREQ      4'h3        // frequency measurement

`endif

// File: logic/enc_ctrl.sv
// Top level of the four-channel encoder interface, filters, counters, velocity and registers
`timescale 1ns/1ps
`include "enc_settings.svh"

module enc_ctrl
    import enc_pkg::*;
(
    input  logic                 sysclk,
    input  logic                 reset,         // active low, synchronous
    input  logic [1:`ENC_NUM_CH] enc_a,         // raw encoder lines
    input  logic [1:`ENC_NUM_CH] enc_b,
    input  logic [15:0]          reg_raddr,
    input  logic [15:0]          reg_waddr,
    input  logic [31:0]          reg_wdata,
    input  logic                 reg_wen,
    output logic [31:0]          reg_rdata
);

    logic [1:`ENC_NUM_CH] enc_a_filt;
    logic [1:`ENC_NUM_CH] enc_b_filt;
    logic [1:`ENC_NUM_CH] dir;          // last counted direction per channel
    logic [1:`ENC_NUM_CH] load;
    logic                 tick_fast;
    logic                 tick_slow;

    enc_preload_t preload   [1:`ENC_NUM_CH];
    enc_count_t   count     [1:`ENC_NUM_CH];
    enc_meas_t    perd_data [1:`ENC_NUM_CH];
    enc_meas_t    freq_data [1:`ENC_NUM_CH];

    // ------------------------------------------------------------------------
    // shared time base
    // ------------------------------------------------------------------------
    enc_tick_gen u_tick_gen (
        .sysclk    (sysclk),
        .reset     (reset),
        .tick_fast (tick_fast),
        .tick_slow (tick_slow)
    );

    // ------------------------------------------------------------------------
    // per-channel datapath
    // ------------------------------------------------------------------------
    for (genvar ch = 1; ch <= `ENC_NUM_CH; ch++)
    begin : g_chan
        enc_debounce u_filt_a (.sysclk(sysclk), .reset(reset),
                               .raw(enc_a[ch]), .filt(enc_a_filt[ch]));
        enc_debounce u_filt_b (.sysclk(sysclk), .reset(reset),
                               .raw(enc_b[ch]), .filt(enc_b_filt[ch]));

        enc_quad_counter u_quad (
            .sysclk  (sysclk),
            .reset   (reset),
            .a       (enc_a_filt[ch]),
            .b       (enc_b_filt[ch]),
            .load    (load[ch]),
            .preload (preload[ch]),
            .count   (count[ch]),
            .dir     (dir[ch])
        );

        enc_period u_perd (.sysclk(sysclk), .reset(reset), .tick_fast(tick_fast),
                           .b(enc_b_filt[ch]), .dir(dir[ch]), .perd(perd_data[ch]));
        enc_freq   u_freq (.sysclk(sysclk), .reset(reset), .tick_slow(tick_slow),
                           .b(enc_b_filt[ch]), .dir(dir[ch]), .freq(freq_data[ch]));
    end

    enc_reg_file u_reg_file (
        .sysclk    (sysclk),
        .reset     (reset),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .reg_rdata (reg_rdata),
        .load      (load),
        .preload   (preload),
        .count     (count),
        .perd      (perd_data),
        .freq      (freq_data)
    );

endmodule

// File: logic/enc_debounce.sv
// Glitch filter for one raw encoder line, synchronizer plus stability counter
`timescale 1ns/1ps
`include "enc_settings.svh"

module enc_debounce (
    input  logic sysclk,
    input  logic reset,                 // active low, synchronous
    input  logic raw,                   // asynchronous encoder line
    output logic filt                   // accepted level
);

    localparam int CNT_W = $clog2(`ENC_FILT_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`ENC_FILT_LEN - 1);

    logic             sync0;
    logic             sync1;            // synchronized level
    logic [CNT_W-1:0] stable_cnt;       // cycles sync1 has differed from filt

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            sync0      <= 1'b0;
            sync1      <= 1'b0;
            stable_cnt <= '0;
            filt       <= 1'b0;
        end
        else
        begin
            sync0 <= raw;
            sync1 <= sync0;
            if (sync1 == filt)
                stable_cnt <= '0;           // pulse ended early, start over
            else if (stable_cnt == CNT_LAST)
            begin
                filt       <= sync1;        // held long enough
                stable_cnt <= '0;
            end
            else
                stable_cnt <= stable_cnt + 1'b1;
        end
    end

endmodule

// File: logic/enc_freq.sv
// Velocity by frequency, counts rising edges of filtered b per slow window
`timescale 1ns/1ps

module enc_freq
    import enc_pkg::*;
(
    input  logic      sysclk,
    input  logic      reset,            // active low, synchronous
    input  logic      tick_slow,        // end of window
    input  logic      b,                // filtered line b
    input  logic      dir,
    output enc_meas_t freq
);

    logic     b_prev;
    logic     b_rise;
    enc_mag_t edge_cnt;                 // rising edges in current window

    assign b_rise = b & ~b_prev;

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            b_prev   <= 1'b0;
            edge_cnt <= '0;
            freq     <= '0;
        end
        else
        begin
            b_prev <= b;
            if (tick_slow)
            begin
                freq.dir <= dir;
                freq.mag <= edge_cnt;
                edge_cnt <= enc_mag_t'(b_rise);  // coincident edge opens next window
            end
            else if (b_rise && edge_cnt != '1)
                edge_cnt <= edge_cnt + 1'b1;
        end
    end

endmodule

// File: logic/enc_period.sv
// Velocity by period, counts fast ticks between rising edges of filtered b
`timescale 1ns/1ps

module enc_period
    import enc_pkg::*;
(
    input  logic      sysclk,
    input  logic      reset,            // active low, synchronous
    input  logic      tick_fast,        // one-cycle time base
    input  logic      b,                // filtered line b
    input  logic      dir,              // from the position counter
    output enc_meas_t perd
);

    logic     b_prev;
    logic     b_rise;
    enc_mag_t tick_cnt;                 // fast ticks since last rising edge

    assign b_rise = b & ~b_prev;

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            b_prev   <= 1'b0;
            tick_cnt <= '0;
            perd     <= '0;
        end
        else
        begin
            b_prev <= b;
            if (b_rise)
            begin
                // publish the interval and restart
                perd.dir <= dir;
                perd.mag <= tick_cnt;
                tick_cnt <= '0;
            end
            else if (tick_fast && tick_cnt != '1)
                tick_cnt <= tick_cnt + 1'b1;    // stalls at 7fff when stopped
        end
    end

endmodule

// File: logic/enc_pkg.sv
// Data types shared by the encoder channels, the register file and the testbench
`include "enc_settings.svh"

package enc_pkg;

    // preload as written by the host
    typedef logic [23:0] enc_preload_t;

    // position counter, sticky wrap flag on top
    typedef struct packed {
        logic         ovf;              // bit 24
        enc_preload_t pos;              // bits 23:0
    } enc_count_t;

    typedef logic [14:0] enc_mag_t;    // velocity magnitude, saturates at 7fff

    // velocity readout, direction in msb
    typedef struct packed {
        logic     dir;                  // 1 = forward
        enc_mag_t mag;
    } enc_meas_t;

    typedef enum logic [3:0] {
        ENC_REG_LOAD = `ENC_OFF_LOAD,
        ENC_REG_DATA = `ENC_OFF_DATA,
        ENC_REG_PERD = `ENC_OFF_PERD,
        ENC_REG_FREQ = `ENC_OFF_FREQ
    } enc_reg_off_e;

endpackage

// File: logic/enc_quad_counter.sv
// 4x quadrature decoder with preloadable 24-bit position and sticky wrap flag
`timescale 1ns/1ps
`include "enc_settings.svh"

module enc_quad_counter
    import enc_pkg::*;
(
    input  logic         sysclk,
    input  logic         reset,         // active low, synchronous
    input  logic         a,             // filtered line a
    input  logic         b,             // filtered line b
    input  logic         load,          // one-cycle preload strobe
    input  enc_preload_t preload,
    output enc_count_t   count,
    output logic         dir            // 1 = last step forward
);

    logic [1:0] ab_prev;                // {a, b} seen last cycle
    logic [1:0] ab_cur;
    logic       step_fwd;
    logic       step_rev;

    assign ab_cur = {a, b};

    // ------------------------------------------------------------------------
    // gray-code step decode, a leading b counts up
    // ------------------------------------------------------------------------
    always_comb
    begin
        step_fwd = 1'b0;
        step_rev = 1'b0;
        case ({ab_prev, ab_cur})
            4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_fwd = 1'b1;
            4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_rev = 1'b1;
            default: ;                  // no change, or both lines moved at once
        endcase
    end

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            ab_prev <= 2'b00;
            count   <= {1'b0, `ENC_PRELOAD_INIT};
            dir     <= 1'b0;
        end
        else
        begin
            ab_prev <= ab_cur;
            if (load)                   // host load wins over a step
            begin
                count.pos <= preload;
                count.ovf <= 1'b0;
            end
            else if (step_fwd)
            begin
                count.pos <= count.pos + 24'd1;
                if (&count.pos)
                    count.ovf <= 1'b1;  // ffffff -> 000000
                dir <= 1'b1;
            end
            else if (step_rev)
            begin
                count.pos <= count.pos - 24'd1;
                if (count.pos == '0)
                    count.ovf <= 1'b1;  // 000000 -> ffffff
                dir <= 1'b0;
            end
        end
    end

endmodule

// File: logic/enc_reg_file.sv
// Host register file, preload storage, load strobes and read data select
`timescale 1ns/1ps
`include "enc_settings.svh"

module enc_reg_file
    import enc_pkg::*;
(
    input  logic                    sysclk,
    input  logic                    reset,      // active low, synchronous
    input  logic [15:0]             reg_raddr,  // level, data follows same cycle
    input  logic [15:0]             reg_waddr,
    input  logic [31:0]             reg_wdata,
    input  logic                    reg_wen,    // one cycle per write
    output logic [31:0]             reg_rdata,
    output logic [1:`ENC_NUM_CH]    load,       // to counters, one cycle
    output enc_preload_t            preload [1:`ENC_NUM_CH],
    input  enc_count_t              count   [1:`ENC_NUM_CH],
    input  enc_meas_t               perd    [1:`ENC_NUM_CH],
    input  enc_meas_t               freq    [1:`ENC_NUM_CH]
);

    localparam int CH_W = `ENC_CH_MSB - `ENC_CH_LSB + 1;

    logic [CH_W-1:0] wr_ch;
    logic            wr_ok;             // qualified preload write
    logic [CH_W-1:0] rd_ch;
    logic            rd_blk_ok;
    enc_reg_off_e    rd_off;

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    assign wr_ch = reg_waddr[`ENC_CH_MSB:`ENC_CH_LSB];
    assign wr_ok = reg_wen
                && (reg_waddr[`ENC_BLK_MSB:`ENC_BLK_LSB] == `ENC_ADDR_MAIN)
                && (reg_waddr[`ENC_OFF_MSB:`ENC_OFF_LSB] == `ENC_OFF_LOAD);

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            load <= '0;
            for (int i = 1; i <= `ENC_NUM_CH; i++)
                preload[i] <= `ENC_PRELOAD_INIT;
        end
        else
        begin
            // channel 0 and channels past ENC_NUM_CH match nothing
            for (int i = 1; i <= `ENC_NUM_CH; i++)
            begin
                load[i] <= wr_ok && (wr_ch == CH_W'(i));
                if (wr_ok && (wr_ch == CH_W'(i)))
                    preload[i] <= reg_wdata[$bits(enc_preload_t)-1:0];
            end
        end
    end

    // ------------------------------------------------------------------------
    // read side, combinational
    // ------------------------------------------------------------------------
    assign rd_ch     = reg_raddr[`ENC_CH_MSB:`ENC_CH_LSB];
    assign rd_blk_ok = (reg_raddr[`ENC_BLK_MSB:`ENC_BLK_LSB] == `ENC_ADDR_MAIN);
    assign rd_off    = enc_reg_off_e'(reg_raddr[`ENC_OFF_MSB:`ENC_OFF_LSB]);

    always_comb
    begin
        reg_rdata = '0;                 // unknown address reads zero
        if (rd_blk_ok)
        begin
            for (int i = 1; i <= `ENC_NUM_CH; i++)
            begin
                if (rd_ch == CH_W'(i))
                begin
                    case (rd_off)
                        ENC_REG_LOAD: reg_rdata = 32'(preload[i]);
                        ENC_REG_DATA: reg_rdata = 32'(count[i]);  // ovf in bit 24
                        ENC_REG_PERD: reg_rdata = 32'(perd[i]);
                        ENC_REG_FREQ: reg_rdata = 32'(freq[i]);
                        default:      reg_rdata = '0;
                    endcase
                end
            end
        end
    end

endmodule

// File: logic/enc_tick_gen.sv
// Prescaler giving the fast tick and the slow window tick as sysclk enables
`timescale 1ns/1ps
`include "enc_settings.svh"

module enc_tick_gen (
    input  logic sysclk,
    input  logic reset,                 // active low, synchronous
    output logic tick_fast,             // every ENC_FAST_DIV cycles
    output logic tick_slow              // every ENC_SLOW_DIV fast ticks
);

    localparam int FAST_W = $clog2(`ENC_FAST_DIV);
    localparam int SLOW_W = $clog2(`ENC_SLOW_DIV);
    localparam logic [FAST_W-1:0] FAST_LAST = FAST_W'(`ENC_FAST_DIV - 1);
    localparam logic [SLOW_W-1:0] SLOW_LAST = SLOW_W'(`ENC_SLOW_DIV - 1);

    logic [FAST_W-1:0] fast_cnt;
    logic [SLOW_W-1:0] slow_cnt;        // fast ticks into current window
    logic              fast_wrap;

    assign fast_wrap = (fast_cnt == FAST_LAST);

    always_ff @(posedge sysclk)
    begin
        if (!reset)
        begin
            fast_cnt  <= '0;
            slow_cnt  <= '0;
            tick_fast <= 1'b0;
            tick_slow <= 1'b0;
        end
        else
        begin
            fast_cnt  <= fast_wrap ? '0 : fast_cnt + 1'b1;
            tick_fast <= fast_wrap;
            tick_slow <= fast_wrap && (slow_cnt == SLOW_LAST);  // last fast tick of window
            if (fast_wrap)
                slow_cnt <= (slow_cnt == SLOW_LAST) ? '0 : slow_cnt + 1'b1;
        end
    end

endmodule

// File: project.f
+incdir+include
logic/enc_pkg.sv
logic/enc_debounce.sv
logic/enc_quad_counter.sv
logic/enc_period.sv
logic/enc_freq.sv
logic/enc_tick_gen.sv
logic/enc_reg_file.sv
logic/enc_ctrl.sv
verification/enc_tb_clock.sv
verification/enc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the encoder interface testbench with Verilator.
# The result is taken from the log, which holds the fail message on any failure.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module enc_tb -Mdir obj_dir > sim.log 2>&1 \
    && ./obj_dir/Venc_tb >> sim.log 2>&1 \
    || echo "STATUS: FAIL" >> sim.log

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// File: verification/enc_tb.sv
// Top-level testbench for enc_ctrl that drives encoder lines and host writes and checks reads
`timescale 1ns/1ps
`include "enc_settings.svh"

module enc_tb
    import enc_pkg::*;
();

    localparam int WIN       = `ENC_FAST_DIV * `ENC_SLOW_DIV;  // sysclk cycles per slow window
    localparam int MAX_STEPS = 40;
    localparam int HOLD      = 10;      // cycles per phase beyond the filter latency
    localparam int SETTLE    = 12;
    localparam int PHASE_TOTAL = `ENC_NUM_CH * 2 * MAX_STEPS + 4 + 2 * `ENC_NUM_CH;
    localparam int TIMEOUT_CYCLES = PHASE_TOTAL * SETTLE + 3 * WIN + 4000;
    localparam longint SPAN = 64'sh1000000;                     // 2**24

    logic                 sysclk;
    logic                 reset;
    logic [1:`ENC_NUM_CH] enc_a;
    logic [1:`ENC_NUM_CH] enc_b;
    logic [15:0]          reg_raddr;
    logic [15:0]          reg_waddr;
    logic [31:0]          reg_wdata;
    logic                 reg_wen;
    logic [31:0]          reg_rdata;

    // ------------------------------------------------------------------------
    // models and bookkeeping
    // ------------------------------------------------------------------------
    logic [31:0]  rng_state = 32'd84181;
    logic [1:0]   phase       [1:`ENC_NUM_CH];  // quadrature position of each channel
    enc_count_t   exp_count   [1:`ENC_NUM_CH];
    enc_preload_t exp_preload [1:`ENC_NUM_CH];
    logic         dir_model   [1:`ENC_NUM_CH];
    string        cur_test;
    int           err_total = 0;        // written by the compare process only
    int           errs_at_start;
    int           pass_cnt = 0;
    int           fail_cnt = 0;
    int           cycle_cnt = 0;
    // read request from stimulus to the compare process
    int           chk_seq = 0;
    int           done_seq = 0;
    string        chk_label;
    logic [31:0]  chk_exp;
    logic [31:0]  chk_mask;
    logic [31:0]  chk_tol;
    logic [31:0]  cmp_act;
    logic [31:0]  cmp_exp;
    logic [31:0]  cmp_diff;

    enc_tb_clock u_clock (.sysclk(sysclk), .reset(reset));

    enc_ctrl u_enc_ctrl (
        .sysclk    (sysclk),
        .reset     (reset),
        .enc_a     (enc_a),
        .enc_b     (enc_b),
        .reg_raddr (reg_raddr),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_wen   (reg_wen),
        .reg_rdata (reg_rdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] draw_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [15:0] make_addr(input logic [3:0] blk, input logic [3:0] ch,
                                              input logic [3:0] off);
        return {blk, 4'h0, ch, off};    // bits 11:8 unused
    endfunction

    // expected {dir, ovf, pos} after fwd steps then rev steps from a fresh preload
    function automatic logic [25:0] enc_expect(input logic [23:0] preload, input int fwd,
                                               input int rev, input logic dir_prev);
        longint pos;
        logic   ovf;
        logic   dir;
        ovf = 1'b0;
        pos = longint'(preload) + fwd;
        if (pos >= SPAN)
        begin
            ovf = 1'b1;                 // wrapped past ffffff
            pos = pos - SPAN;
        end
        pos = pos - rev;
        if (pos < 0)
        begin
            ovf = 1'b1;
            pos = pos + SPAN;
        end
        dir = (rev > 0) ? 1'b0 : ((fwd > 0) ? 1'b1 : dir_prev);
        return {dir, ovf, pos[23:0]};
    endfunction

    // ------------------------------------------------------------------------
    // stimulus helpers start and end just after a rising edge
    // ------------------------------------------------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysclk);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);              // write taken on this edge
        reg_wen   <= 1'b0;
        @(posedge sysclk);              // count follows as the load pulse ends
    endtask

    task automatic read_check(input string label, input logic [15:0] addr,
                              input logic [31:0] exp, input logic [31:0] mask,
                              input logic [31:0] tol);
        reg_raddr <= addr;
        chk_label = label;
        chk_exp   = exp;
        chk_mask  = mask;
        chk_tol   = tol;
        chk_seq++;
        wait (done_seq == chk_seq);     // compared at the falling edge
        @(posedge sysclk);
    endtask

    task automatic check_reg(input string label, input logic [15:0] addr, input logic [31:0] exp);
        read_check(label, addr, exp, 32'hffff_ffff, 0);
    endtask

    task automatic step_channel(input int ch, input logic fwd, input int hold);
        phase[ch] = fwd ? phase[ch] + 2'd1 : phase[ch] - 2'd1;
        enc_a[ch] <= phase[ch][0] ^ phase[ch][1];  // a leads b going forward through 00 10 11 01
        enc_b[ch] <= phase[ch][1];
        wait_cycles(hold);
    endtask

    task automatic pulse_line(input int ch, input logic on_b);
        logic [15:0] addr;
        string       label;
        addr  = make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_DATA);
        label = $sformatf("ch%0d count during glitch", ch);
        if (on_b)
            enc_b[ch] <= ~phase[ch][1];
        else
            enc_a[ch] <= ~(phase[ch][0] ^ phase[ch][1]);
        // one read per cycle, a leaked pulse would show as a step and back
        repeat (2) check_reg(label, addr, 32'(exp_count[ch]));
        enc_a[ch] <= phase[ch][0] ^ phase[ch][1];
        enc_b[ch] <= phase[ch][1];
        repeat (HOLD) check_reg(label, addr, 32'(exp_count[ch]));
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = err_total;
    endtask

    task automatic finish_test();
        if (err_total == errs_at_start)
        begin
            pass_cnt++;
            $display("test %s: passed", cur_test);
        end
        else
        begin
            fail_cnt++;
            $display("test %s: failed with %0d mismatches", cur_test, err_total - errs_at_start);
        end
    endtask

    task automatic check_all_channels();
        for (int c = 1; c <= `ENC_NUM_CH; c++)
        begin
            check_reg($sformatf("ch%0d preload", c), make_addr(`ENC_ADDR_MAIN, 4'(c),
                      `ENC_OFF_LOAD), 32'(exp_preload[c]));
            check_reg($sformatf("ch%0d count", c), make_addr(`ENC_ADDR_MAIN, 4'(c),
                      `ENC_OFF_DATA), 32'(exp_count[c]));
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic test_reset();
        start_test("reset");
        check_all_channels();
        for (int c = 1; c <= `ENC_NUM_CH; c++)
        begin
            check_reg($sformatf("ch%0d perd", c),
                      make_addr(`ENC_ADDR_MAIN, 4'(c), `ENC_OFF_PERD), 0);
            check_reg($sformatf("ch%0d freq", c),
                      make_addr(`ENC_ADDR_MAIN, 4'(c), `ENC_OFF_FREQ), 0);
        end
        check_reg("offset 5", make_addr(`ENC_ADDR_MAIN, 4'd1, 4'd5), 0);
        check_reg("channel 0", make_addr(`ENC_ADDR_MAIN, 4'd0, `ENC_OFF_LOAD), 0);
        finish_test();
    endtask

    task automatic test_preload();
        int          ch;
        logic [31:0] data;
        start_test("preload");
        ch   = 1 + int'(draw_random() % `ENC_NUM_CH);
        data = draw_random();           // upper byte must be dropped
        write_reg(make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_LOAD), data);
        exp_preload[ch] = data[23:0];
        exp_count[ch]   = {1'b0, data[23:0]};
        check_all_channels();
        // none of these qualify
        write_reg(make_addr(4'h1, 4'(ch), `ENC_OFF_LOAD), ~data);
        write_reg(make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_DATA), ~data);
        write_reg(make_addr(`ENC_ADDR_MAIN, 4'd0, `ENC_OFF_LOAD), ~data);
        check_all_channels();
        finish_test();
    endtask

    task automatic test_counting();
        int          fwd;
        int          rev;
        logic [31:0] data;
        logic [25:0] res;
        start_test("counting");
        for (int c = 1; c <= `ENC_NUM_CH; c++)
        begin
            data = draw_random() & 32'h00ff_ffff;
            write_reg(make_addr(`ENC_ADDR_MAIN, 4'(c), `ENC_OFF_LOAD), data);
            exp_preload[c] = data[23:0];
            fwd = 1 + int'(draw_random() % MAX_STEPS);
            rev = 5 + int'(draw_random() % (MAX_STEPS - 4));  // at least one b rise in reverse
            repeat (fwd) step_channel(c, 1'b1, HOLD);
            repeat (rev) step_channel(c, 1'b0, HOLD);
            wait_cycles(SETTLE);
            res = enc_expect(data[23:0], fwd, rev, dir_model[c]);
            exp_count[c] = res[24:0];
            dir_model[c] = res[25];
            check_reg($sformatf("ch%0d count", c), make_addr(`ENC_ADDR_MAIN, 4'(c),
                      `ENC_OFF_DATA), 32'(exp_count[c]));
        end
        wait_cycles(WIN + 4);           // one slow window refreshes freq
        for (int c = 1; c <= `ENC_NUM_CH; c++)
        begin
            read_check($sformatf("ch%0d perd dir", c), make_addr(`ENC_ADDR_MAIN, 4'(c),
                       `ENC_OFF_PERD), 32'(dir_model[c]) << 15, 32'h8000, 0);
            read_check($sformatf("ch%0d freq dir", c), make_addr(`ENC_ADDR_MAIN, 4'(c),
                       `ENC_OFF_FREQ), 32'(dir_model[c]) << 15, 32'h8000, 0);
        end
        finish_test();
    endtask

    task automatic test_overflow();
        int          ch;
        logic [31:0] data;
        start_test("overflow");
        ch = 1 + int'(draw_random() % `ENC_NUM_CH);
        write_reg(make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_LOAD), 32'h00ff_fffe);
        repeat (4) step_channel(ch, 1'b1, HOLD);
        wait_cycles(SETTLE);
        check_reg("wrap count", make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_DATA), 32'h0100_0002);
        dir_model[ch] = 1'b1;
        data = draw_random() & 32'h00ff_ffff;
        write_reg(make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_LOAD), data);
        exp_preload[ch] = data[23:0];
        exp_count[ch]   = {1'b0, data[23:0]};   // flag cleared by the load
        check_reg("flag cleared", make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_DATA),
                  32'(exp_count[ch]));
        finish_test();
    endtask

    task automatic test_glitch();
        start_test("glitch");
        for (int c = 1; c <= `ENC_NUM_CH; c++)
        begin
            pulse_line(c, 1'b0);
            pulse_line(c, 1'b1);
            wait_cycles(SETTLE);
        end
        check_all_channels();
        finish_test();
    endtask

    task automatic test_velocity();
        int ch;
        int per;                        // sysclk cycles between b rising edges
        int n_steps;
        start_test("velocity");
        ch      = 1 + int'(draw_random() % `ENC_NUM_CH);
        per     = 32 + 8 * int'(draw_random() % 5);
        n_steps = 4 * (2 * WIN + 2 * per) / per;
        fork
            repeat (n_steps) step_channel(ch, 1'b1, per / 4);
            begin
                wait_cycles(2 * WIN + per);     // read while still moving
                read_check("period", make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_PERD),
                           32'h8000 | 32'(per / `ENC_FAST_DIV), 32'hffff, 1);
                read_check("freq", make_addr(`ENC_ADDR_MAIN, 4'(ch), `ENC_OFF_FREQ),
                           32'h8000 | 32'(WIN / per), 32'hffff, 1);
            end
        join
        finish_test();
    endtask

    // ------------------------------------------------------------------------
    // compare process samples the combinational read data mid-cycle
    // ------------------------------------------------------------------------
    always @(negedge sysclk)
    begin
        if (done_seq != chk_seq)
        begin
            cmp_act  = reg_rdata & chk_mask;
            cmp_exp  = chk_exp & chk_mask;
            cmp_diff = (cmp_act > cmp_exp) ? cmp_act - cmp_exp : cmp_exp - cmp_act;
            if (cmp_diff > chk_tol)
            begin
                $display("** Error: %s %s expected %h actual %h",
                         cur_test, chk_label, cmp_exp, cmp_act);
                err_total++;
            end
            done_seq = chk_seq;
        end
    end

    always @(posedge sysclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("simulation hung, no result after %0d cycles", cycle_cnt);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial
    begin
        enc_a     <= '0;
        enc_b     <= '0;
        reg_raddr <= '0;
        reg_waddr <= '0;
        reg_wdata <= '0;
        reg_wen   <= 1'b0;
        for (int c = 1; c <= `ENC_NUM_CH; c++)
        begin
            phase[c]       = 2'd0;
            exp_preload[c] = `ENC_PRELOAD_INIT;
            exp_count[c]   = {1'b0, `ENC_PRELOAD_INIT};
            dir_model[c]   = 1'b0;
        end
        wait (reset === 1'b1);
        @(posedge sysclk);
        test_reset();
        test_preload();
        test_counting();
        test_overflow();
        test_glitch();
        test_velocity();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: verification/enc_tb_clock.sv
// Testbench clock and reset source for the encoder interface, 20 ns period, reset low 3 cycles
`timescale 1ns/1ps

module enc_tb_clock (
    output logic sysclk,
    output logic reset                  // active low, synchronous
);

    initial
    begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;   // 50 MHz
    end

    initial
    begin
        reset = 1'b0;
        repeat (3) @(posedge sysclk);
        reset <= 1'b1;                  // released on the third rising edge
    end

endmodule
